// File: verification/tcp_conn_engine_testdata.txt
// One scenario per line, all values hex
// kind loc_port rem_port rem_addr rem_seq close_flags wnd
// kind: high digit open (1 active, 2 passive), low digit close (0 none, 1 active, 2 passive, 3 reset)
// close_flags: flags of the first segment the engine sends to close, wnd: advertised window

// Active open
11 1F90 C350 C0A8000A 00001000 11 0FA0
12 1F91 C351 C0A8000B 7FFF0000 10 0FA0
13 0050 D431 0A000001 12345678 14 0FA0
12 2710 0400 AC100203 FFFFFFFF 10 0FA0

// Passive open
21 0016 E001 C0A80114 00ABCDEF 11 0FA0
22 01BB E002 C0A80115 FFFFFFFE 10 0FA0
23 0019 E003 0A0A0A0A 55AA55AA 14 0FA0
21 C000 0035 08080808 80000000 11 0FA0

// SYN never answered, open timeout
10 1F92 C352 C0A8000C 00000000 00 0FA0

// End of list
00 0000 0000 00000000 00000000 00 0000

// File: tb.f
source/tcp_conn_pkg.sv
source/tcp_seq_lfsr.sv
source/tcp_conn_timer.sv
source/tcp_rx_classify.sv
source/tcp_conn_fsm.sv
source/tcp_seg_gen.sv
source/tcp_conn_engine.sv
verification/tcp_conn_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tcp_conn_engine_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tcp_conn_engine_tb.sv
`timescale 1ns/1ps

module tcp_conn_engine_tb;

  import tcp_conn_pkg::*;

  localparam int CLK_HALF    = 10;  // 20 ns period
  localparam int RST_CYCLES  = 8;
  localparam int SEG_WAIT    = 4;   // Cycles allowed for a segment to be offered
  localparam int STATUS_WAIT = 10;
  localparam int REC_W       = 7;   // Words per scenario record
  localparam int MAX_REC     = 16;

  logic                clk;
  logic                rst_rec;
  logic                connect;
  logic                listen;
  logic [PORT_W-1:0]   loc_port;
  logic [PORT_W-1:0]   rem_port;
  logic [ADDR_W-1:0]   rem_addr;
  logic                rx_val;
  logic [ADDR_W-1:0]   rx_src_addr;
  logic [PORT_W-1:0]   rx_src_port;
  logic [PORT_W-1:0]   rx_dst_port;
  logic [NUM_W-1:0]    rx_seq;
  logic [NUM_W-1:0]    rx_ack;
  logic [FLAGS_W-1:0]  rx_flags;
  logic                tx_rdy;
  logic                tx_acc;
  logic                tx_done;
  logic [ADDR_W-1:0]   tx_dst_addr;
  logic [PORT_W-1:0]   tx_src_port;
  logic [PORT_W-1:0]   tx_dst_port;
  logic [NUM_W-1:0]    tx_seq;
  logic [NUM_W-1:0]    tx_ack;
  logic [FLAGS_W-1:0]  tx_flags;
  logic [15:0]         tx_wnd;
  logic [STATUS_W-1:0] status;

  logic [31:0] stim [0:REC_W*MAX_REC-1];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  // Current record
  logic [15:0] rec_loc_port;
  logic [15:0] rec_rem_port;
  logic [31:0] rec_rem_addr;
  logic [31:0] rec_rem_seq;
  logic [7:0]  rec_close_flags;
  logic [15:0] rec_wnd;
  logic [31:0] iss;           // Engine's initial sequence number as read from its first segment

  // Last header taken from the transmit port
  logic [7:0]  seg_flags;
  logic [31:0] seg_seq;
  logic [31:0] seg_ack;
  logic [31:0] seg_dst_addr;
  logic [15:0] seg_src_port;
  logic [15:0] seg_dst_port;
  logic [15:0] seg_wnd;

  tcp_conn_engine i_tcp_conn_engine (
    .clk         (clk),
    .rst_rec     (rst_rec),
    .connect     (connect),
    .listen      (listen),
    .loc_port    (loc_port),
    .rem_port    (rem_port),
    .rem_addr    (rem_addr),
    .rx_val      (rx_val),
    .rx_src_addr (rx_src_addr),
    .rx_src_port (rx_src_port),
    .rx_dst_port (rx_dst_port),
    .rx_seq      (rx_seq),
    .rx_ack      (rx_ack),
    .rx_flags    (rx_flags),
    .tx_rdy      (tx_rdy),
    .tx_acc      (tx_acc),
    .tx_done     (tx_done),
    .tx_dst_addr (tx_dst_addr),
    .tx_src_port (tx_src_port),
    .tx_dst_port (tx_dst_port),
    .tx_seq      (tx_seq),
    .tx_ack      (tx_ack),
    .tx_flags    (tx_flags),
    .tx_wnd      (tx_wnd),
    .status      (status)
  );

  always #CLK_HALF clk = ~clk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  ////////////////////
  // Bus helpers
  ////////////////////
  task automatic apply_reset();
    @(negedge clk);
    rst_rec = 1'b1;
    connect = 1'b0;
    listen  = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_rec = 1'b0;
    @(negedge clk);
    check_value("tx_rdy", 32'(tx_rdy), 32'd0);
    check_value("status", 32'(status), 32'(ST_CLOSED));
  endtask

  task automatic send_rx(input logic [7:0] flags, input logic [31:0] seq,
                         input logic [31:0] ack, input logic [15:0] dst_port);
    rx_val      = 1'b1;    // One-cycle strobe
    rx_flags    = flags;
    rx_seq      = seq;
    rx_ack      = ack;
    rx_src_addr = rec_rem_addr;
    rx_src_port = rec_rem_port;
    rx_dst_port = dst_port;
    @(negedge clk);
    rx_val   = 1'b0;
    rx_flags = '0;
  endtask

  task automatic wait_segment();
    int n;
    n = 0;
    while (tx_rdy !== 1'b1 && n < SEG_WAIT) begin
      @(negedge clk);
      n++;
    end
    assert (tx_rdy === 1'b1) else begin
      errors++;
      $display("timeout at %0t ns: no segment offered within %0d cycles", $time, SEG_WAIT);
    end
    seg_flags    = tx_flags;
    seg_seq      = tx_seq;
    seg_ack      = tx_ack;
    seg_dst_addr = tx_dst_addr;
    seg_src_port = tx_src_port;
    seg_dst_port = tx_dst_port;
    seg_wnd      = tx_wnd;
  endtask

  // Back-pressure of 0 to 3 cycles, then accept and later report the segment sent
  task automatic release_segment();
    repeat (lcg_next() % 4) begin
      @(negedge clk);
      check_value("tx_rdy", 32'(tx_rdy), 32'd1);
      check_value("tx_seq", tx_seq, seg_seq);
    end
    tx_acc = 1'b1;
    @(negedge clk);
    tx_acc = 1'b0;
    check_value("tx_rdy", 32'(tx_rdy), 32'd0);
    repeat (1 + lcg_next() % 3) @(negedge clk);
    tx_done = 1'b1;
    @(negedge clk);
    tx_done = 1'b0;
  endtask

  task automatic wait_status(input logic [STATUS_W-1:0] want, input int limit);
    int n;
    n = 0;
    while (status !== want && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (status === want) else begin
      errors++;
      $display("timeout at %0t ns: status stayed %0d, waited %0d cycles for %0d",
               $time, status, limit, want);
    end
  endtask

  task automatic check_fields(input logic [7:0] flags, input logic [31:0] ack);
    check_value("tx_flags", 32'(seg_flags), 32'(flags));
    check_value("tx_ack", seg_ack, ack);
    check_value("tx_src_port", 32'(seg_src_port), 32'(rec_loc_port));
    check_value("tx_dst_port", 32'(seg_dst_port), 32'(rec_rem_port));
    check_value("tx_dst_addr", seg_dst_addr, rec_rem_addr);
    check_value("tx_wnd", 32'(seg_wnd), 32'(rec_wnd));
  endtask

  task automatic check_header(input logic [7:0] flags, input logic [31:0] seq,
                              input logic [31:0] ack);
    check_value("tx_seq", seg_seq, seq);
    check_fields(flags, ack);
  endtask

  ////////////////////
  // Open
  ////////////////////
  task automatic active_open(input bit no_answer);
    connect = 1'b1;
    wait_segment();
    iss = seg_seq;
    check_fields(FLAG_SYN, 32'd0);
    check_value("status", 32'(status), 32'(ST_CONNECTING));
    if (no_answer) begin
      // SYN left waiting so only the open timeout ends it
      wait_status(ST_CLOSED, int'(CONN_TIMEOUT_TICKS) + 10);
      connect = 1'b0;
      check_value("tx_rdy", 32'(tx_rdy), 32'd0);
    end else begin
      release_segment();
      send_rx(FLAG_SYN | FLAG_ACK, rec_rem_seq, iss + 1, rec_loc_port);
      wait_segment();
      check_header(FLAG_ACK, iss + 1, rec_rem_seq + 1);
      release_segment();
      wait_status(ST_CONNECTED, STATUS_WAIT);
    end
  endtask

  task automatic passive_open();
    listen = 1'b1;
    wait_status(ST_LISTENING, STATUS_WAIT);
    send_rx(FLAG_SYN, rec_rem_seq, 32'd0, rec_loc_port + 16'd1); // Some other port
    repeat (6) begin
      @(negedge clk);
      check_value("tx_rdy", 32'(tx_rdy), 32'd0);
      check_value("status", 32'(status), 32'(ST_LISTENING));
    end
    send_rx(FLAG_SYN, rec_rem_seq, 32'd0, rec_loc_port);
    wait_segment();
    iss = seg_seq;
    check_fields(FLAG_SYN | FLAG_ACK, rec_rem_seq + 1);
    check_value("status", 32'(status), 32'(ST_CONNECTING));
    release_segment();
    send_rx(FLAG_ACK, rec_rem_seq + 1, iss + 1, rec_loc_port);
    wait_status(ST_CONNECTED, STATUS_WAIT);
  endtask

  ////////////////////
  // Close
  ////////////////////
  task automatic active_close();
    connect = 1'b0;
    listen  = 1'b0;
    wait_segment();
    check_header(rec_close_flags, iss + 1, rec_rem_seq + 1);
    check_value("status", 32'(status), 32'(ST_DISCONNECTING));
    release_segment();
    send_rx(FLAG_ACK, rec_rem_seq + 1, iss + 2, rec_loc_port);
    send_rx(FLAG_FIN | FLAG_ACK, rec_rem_seq + 1, iss + 2, rec_loc_port);
    wait_segment();
    check_header(FLAG_ACK, iss + 1, rec_rem_seq + 2); // Covers the remote FIN
    release_segment();
    wait_status(ST_CLOSED, STATUS_WAIT);
  endtask

  task automatic passive_close();
    send_rx(FLAG_FIN | FLAG_ACK, rec_rem_seq + 1, iss + 1, rec_loc_port);
    wait_segment();
    check_header(rec_close_flags, iss + 1, rec_rem_seq + 2);
    check_value("status", 32'(status), 32'(ST_DISCONNECTING));
    release_segment();
    wait_segment();
    check_header(FLAG_FIN | FLAG_ACK, iss + 1, rec_rem_seq + 2);
    connect = 1'b0;   // Keeps the engine closed once it clears
    listen  = 1'b0;
    release_segment();
    send_rx(FLAG_ACK, rec_rem_seq + 2, iss + 2, rec_loc_port);
    wait_status(ST_CLOSED, STATUS_WAIT);
  endtask

  task automatic reset_close();
    send_rx(FLAG_RST, rec_rem_seq + 1, iss + 1, rec_loc_port);
    wait_segment();
    check_header(rec_close_flags, iss + 1, rec_rem_seq + 1);
    check_value("status", 32'(status), 32'(ST_DISCONNECTING));
    connect = 1'b0;
    listen  = 1'b0;
    release_segment();
    wait_status(ST_CLOSED, STATUS_WAIT);
  endtask

  // Kind holds the open mode in its high digit and the close mode in its low digit
  task automatic run_scenario(input int base);
    logic [3:0] open_mode;
    logic [3:0] close_mode;
    open_mode       = stim[base][7:4];
    close_mode      = stim[base][3:0];
    rec_loc_port    = stim[base+1][15:0];
    rec_rem_port    = stim[base+2][15:0];
    rec_rem_addr    = stim[base+3];
    rec_rem_seq     = stim[base+4];
    rec_close_flags = stim[base+5][7:0];
    rec_wnd         = stim[base+6][15:0];
    $display("scenario %0d: kind %h, local port %0d", base / REC_W, stim[base][7:0],
             rec_loc_port);
    loc_port = rec_loc_port;
    rem_port = rec_rem_port;
    rem_addr = rec_rem_addr;
    apply_reset();
    if (open_mode == 4'h1) begin
      active_open(close_mode == 4'h0);
    end else begin
      passive_open();
    end
    case (close_mode)
      4'h1: active_close();
      4'h2: passive_close();
      4'h3: reset_close();
      default: ;
    endcase
  endtask

  initial begin
    int i;
    int rec;
    clk         = 1'b0;
    rst_rec     = 1'b1;
    connect     = 1'b0;
    listen      = 1'b0;
    loc_port    = '0;
    rem_port    = '0;
    rem_addr    = '0;
    rx_val      = 1'b0;
    rx_src_addr = '0;
    rx_src_port = '0;
    rx_dst_port = '0;
    rx_seq      = '0;
    rx_ack      = '0;
    rx_flags    = '0;
    tx_acc      = 1'b0;
    tx_done     = 1'b0;
    lcg_state   = 32'd90;
    errors      = 0;
    checks      = 0;
    for (i = 0; i < REC_W * MAX_REC; i++) begin
      stim[i] = '0;
    end
    $readmemh("verification/tcp_conn_engine_testdata.txt", stim);

    rec = 0;
    while (rec < MAX_REC && stim[rec * REC_W] != '0) begin // Kind 00 ends the list
      run_scenario(rec * REC_W);
      rec++;
    end
    assert (rec != 0) else begin
      errors++;
      $display("no scenario records were read from the data file");
    end

    $display("scenarios: %0d, checks: %0d, errors: %0d", rec, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: source/tcp_conn_engine.sv
`timescale 1ns/1ps

module tcp_conn_engine (
  input  logic                              clk,
  input  logic                              rst_rec,
  input  logic                              connect,
  input  logic                              listen,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   loc_port,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   rem_port,
  input  logic [tcp_conn_pkg::ADDR_W-1:0]   rem_addr,
  input  logic                              rx_val,
  input  logic [tcp_conn_pkg::ADDR_W-1:0]   rx_src_addr,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   rx_src_port,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   rx_dst_port,
  input  logic [tcp_conn_pkg::NUM_W-1:0]    rx_seq,
  input  logic [tcp_conn_pkg::NUM_W-1:0]    rx_ack,
  input  logic [tcp_conn_pkg::FLAGS_W-1:0]  rx_flags,
  output logic                              tx_rdy,
  input  logic                              tx_acc,
  input  logic                              tx_done,
  output logic [tcp_conn_pkg::ADDR_W-1:0]   tx_dst_addr,
  output logic [tcp_conn_pkg::PORT_W-1:0]   tx_src_port,
  output logic [tcp_conn_pkg::PORT_W-1:0]   tx_dst_port,
  output logic [tcp_conn_pkg::NUM_W-1:0]    tx_seq,
  output logic [tcp_conn_pkg::NUM_W-1:0]    tx_ack,
  output logic [tcp_conn_pkg::FLAGS_W-1:0]  tx_flags,
  output logic [15:0]                       tx_wnd,
  output logic [tcp_conn_pkg::STATUS_W-1:0] status
);

  import tcp_conn_pkg::*;

  logic               syn_seen;
  logic               syn_ack_seen;
  logic               ack_seen;
  logic               fin_seen;
  logic               rst_seen;
  logic               conn_ack_seen;
  logic [NUM_W-1:0]   isn;
  logic               timer_run;
  logic               timeout;
  logic               conn_clear;
  logic               send_req;
  logic [FLAGS_W-1:0] hdr_flags;
  logic [NUM_W-1:0]   hdr_seq;
  logic [NUM_W-1:0]   hdr_ack;
  logic [ADDR_W-1:0]  conn_rem_addr;
  logic [PORT_W-1:0]  conn_loc_port;
  logic [PORT_W-1:0]  conn_rem_port;
  logic [NUM_W-1:0]   rem_seq;
  logic               seg_acc;
  logic               seg_done;

  tcp_seq_lfsr i_tcp_seq_lfsr (
    .clk     (clk),
    .rst_rec (rst_rec),
    .value   (isn)
  );

  tcp_conn_timer i_tcp_conn_timer (
    .clk     (clk),
    .rst_rec (rst_rec),
    .run     (timer_run),
    .timeout (timeout)
  );

  tcp_rx_classify i_tcp_rx_classify (
    .rx_val        (rx_val),
    .rx_dst_port   (rx_dst_port),
    .rx_src_port   (rx_src_port),
    .rx_flags      (rx_flags),
    .rx_seq        (rx_seq),
    .conn_loc_port (conn_loc_port),
    .conn_rem_port (conn_rem_port),
    .rem_seq       (rem_seq),
    .loc_port      (loc_port),
    .syn_seen      (syn_seen),
    .syn_ack_seen  (syn_ack_seen),
    .ack_seen      (ack_seen),
    .fin_seen      (fin_seen),
    .rst_seen      (rst_seen),
    .conn_ack_seen (conn_ack_seen)
  );

  tcp_conn_fsm i_tcp_conn_fsm (
    .clk           (clk),
    .rst_rec       (rst_rec),
    .connect       (connect),
    .listen        (listen),
    .loc_port      (loc_port),
    .rem_port      (rem_port),
    .rem_addr      (rem_addr),
    .rx_src_addr   (rx_src_addr),
    .rx_src_port   (rx_src_port),
    .rx_seq        (rx_seq),
    .rx_ack        (rx_ack),
    .syn_seen      (syn_seen),
    .syn_ack_seen  (syn_ack_seen),
    .ack_seen      (ack_seen),
    .fin_seen      (fin_seen),
    .rst_seen      (rst_seen),
    .conn_ack_seen (conn_ack_seen),
    .isn           (isn),
    .timeout       (timeout),
    .seg_acc       (seg_acc),
    .seg_done      (seg_done),
    .status        (status),
    .timer_run     (timer_run),
    .conn_clear    (conn_clear),
    .send_req      (send_req),
    .hdr_flags     (hdr_flags),
    .hdr_seq       (hdr_seq),
    .hdr_ack       (hdr_ack),
    .conn_rem_addr (conn_rem_addr),
    .conn_loc_port (conn_loc_port),
    .conn_rem_port (conn_rem_port),
    .rem_seq       (rem_seq)
  );

  // Cleared with the connection, so a header left waiting at timeout is dropped
  tcp_seg_gen i_tcp_seg_gen (
    .clk          (clk),
    .rst_rec      (conn_clear),
    .send_req     (send_req),
    .hdr_flags    (hdr_flags),
    .hdr_seq      (hdr_seq),
    .hdr_ack      (hdr_ack),
    .hdr_dst_addr (conn_rem_addr),
    .hdr_src_port (conn_loc_port),
    .hdr_dst_port (conn_rem_port),
    .tx_acc       (tx_acc),
    .tx_done      (tx_done),
    .tx_rdy       (tx_rdy),
    .tx_dst_addr  (tx_dst_addr),
    .tx_src_port  (tx_src_port),
    .tx_dst_port  (tx_dst_port),
    .tx_seq       (tx_seq),
    .tx_ack       (tx_ack),
    .tx_flags     (tx_flags),
    .tx_wnd       (tx_wnd),
    .seg_acc      (seg_acc),
    .seg_done     (seg_done)
  );

endmodule

// File: source/tcp_seg_gen.sv
`timescale 1ns/1ps

module tcp_seg_gen (
  input  logic                             clk,
  input  logic                             rst_rec,
  input  logic                             send_req,
  input  logic [tcp_conn_pkg::FLAGS_W-1:0] hdr_flags,
  input  logic [tcp_conn_pkg::NUM_W-1:0]   hdr_seq,
  input  logic [tcp_conn_pkg::NUM_W-1:0]   hdr_ack,
  input  logic [tcp_conn_pkg::ADDR_W-1:0]  hdr_dst_addr,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  hdr_src_port,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  hdr_dst_port,
  input  logic                             tx_acc,
  input  logic                             tx_done,
  output logic                             tx_rdy,
  output logic [tcp_conn_pkg::ADDR_W-1:0]  tx_dst_addr,
  output logic [tcp_conn_pkg::PORT_W-1:0]  tx_src_port,
  output logic [tcp_conn_pkg::PORT_W-1:0]  tx_dst_port,
  output logic [tcp_conn_pkg::NUM_W-1:0]   tx_seq,
  output logic [tcp_conn_pkg::NUM_W-1:0]   tx_ack,
  output logic [tcp_conn_pkg::FLAGS_W-1:0] tx_flags,
  output logic [15:0]                      tx_wnd,
  output logic                             seg_acc,
  output logic                             seg_done
);

  import tcp_conn_pkg::*;

  // Strobe held until the consumer takes the header
  always_ff @(posedge clk) begin
    if (rst_rec) begin
      tx_rdy   <= 1'b0;
      seg_acc  <= 1'b0;
      seg_done <= 1'b0;
    end else begin
      seg_acc  <= tx_acc;
      seg_done <= tx_done;
      if (send_req) begin
        tx_rdy <= 1'b1;
      end else if (tx_acc) begin
        tx_rdy <= 1'b0;
      end
    end
  end

  // Header stays put while tx_rdy is up
  always_ff @(posedge clk) begin
    if (send_req) begin
      tx_dst_addr <= hdr_dst_addr;
      tx_src_port <= hdr_src_port;
      tx_dst_port <= hdr_dst_port;
      tx_seq      <= hdr_seq;
      tx_ack      <= hdr_ack;
      tx_flags    <= hdr_flags;
      tx_wnd      <= WINDOW_SIZE;
    end
  end

endmodule

// File: source/tcp_conn_fsm.sv
`timescale 1ns/1ps

module tcp_conn_fsm (
  input  logic                              clk,
  input  logic                              rst_rec,
  input  logic                              connect,
  input  logic                              listen,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   loc_port,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   rem_port,
  input  logic [tcp_conn_pkg::ADDR_W-1:0]   rem_addr,
  input  logic [tcp_conn_pkg::ADDR_W-1:0]   rx_src_addr,
  input  logic [tcp_conn_pkg::PORT_W-1:0]   rx_src_port,
  input  logic [tcp_conn_pkg::NUM_W-1:0]    rx_seq,
  input  logic [tcp_conn_pkg::NUM_W-1:0]    rx_ack,
  input  logic                              syn_seen,
  input  logic                              syn_ack_seen,
  input  logic                              ack_seen,
  input  logic                              fin_seen,
  input  logic                              rst_seen,
  input  logic                              conn_ack_seen,
  input  logic [tcp_conn_pkg::NUM_W-1:0]    isn,
  input  logic                              timeout,
  input  logic                              seg_acc,
  input  logic                              seg_done,
  output logic [tcp_conn_pkg::STATUS_W-1:0] status,
  output logic                              timer_run,
  output logic                              conn_clear,
  output logic                              send_req,
  output logic [tcp_conn_pkg::FLAGS_W-1:0]  hdr_flags,
  output logic [tcp_conn_pkg::NUM_W-1:0]    hdr_seq,
  output logic [tcp_conn_pkg::NUM_W-1:0]    hdr_ack,
  output logic [tcp_conn_pkg::ADDR_W-1:0]   conn_rem_addr,
  output logic [tcp_conn_pkg::PORT_W-1:0]   conn_loc_port,
  output logic [tcp_conn_pkg::PORT_W-1:0]   conn_rem_port,
  output logic [tcp_conn_pkg::NUM_W-1:0]    rem_seq
);

  import tcp_conn_pkg::*;

  logic [4:0]       state;
  logic [1:0]       close_kind;
  logic             is_server;  // Opened passively, closed by dropping listen
  logic             fin_acked;  // Remote has ACKed our FIN
  logic [NUM_W-1:0] loc_seq;
  logic [NUM_W-1:0] loc_ack;
  logic             usr_close;
  logic             close_done;

  assign usr_close = is_server ? !listen : !connect;

  // Passive close ends on the last remote ACK, the others once our final segment left
  assign close_done = (state == fin_sent && close_kind == close_passive && conn_ack_seen) ||
                      (state == dcn_ack_sent && close_kind != close_passive && seg_done);

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      conn_clear <= 1'b1;
    end else begin
      conn_clear <= timeout || close_done;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_rec || conn_clear) begin
      state      <= closed;
      status     <= ST_CLOSED;
      timer_run  <= 1'b0;
      send_req   <= 1'b0;
      close_kind <= close_none;
      is_server  <= 1'b0;
      fin_acked  <= 1'b0;
    end else begin
      send_req <= 1'b0; // One cycle per segment
      case (state)
        closed : begin
          if (listen) begin
            is_server <= 1'b1;
            state     <= tcp_conn_pkg::listen; // The input port shadows the state name
          end else if (connect) begin
            is_server <= 1'b0;
            state     <= send_syn;
          end
        end

        ////////////////////
        // Active open
        ////////////////////
        send_syn : begin
          status        <= ST_CONNECTING;
          timer_run     <= 1'b1;
          conn_rem_addr <= rem_addr;
          conn_loc_port <= loc_port;
          conn_rem_port <= rem_port;
          loc_seq       <= isn;
          loc_ack       <= '0;  // Remote number not known yet
          send_req      <= 1'b1;
          hdr_flags     <= FLAG_SYN;
          hdr_seq       <= isn;
          hdr_ack       <= '0;
          state         <= syn_sent;
        end
        syn_sent : begin
          if (syn_ack_seen && (rx_ack == loc_seq + 1)) begin
            rem_seq <= rx_seq + 1;
            loc_seq <= loc_seq + 1; // Our SYN took one number
            loc_ack <= rx_seq + 1;
            state   <= send_ack;
          end
        end
        send_ack : begin
          send_req  <= 1'b1;
          hdr_flags <= FLAG_ACK;
          hdr_seq   <= loc_seq;
          hdr_ack   <= loc_ack;
          state     <= ack_sent;
        end
        ack_sent : begin
          if (seg_done) state <= established;
        end

        ////////////////////
        // Passive open
        ////////////////////
        tcp_conn_pkg::listen : begin
          status <= ST_LISTENING;
          if (!listen) begin
            status <= ST_CLOSED;
            state  <= closed;
          end else if (syn_seen) begin
            conn_rem_addr <= rx_src_addr;
            conn_rem_port <= rx_src_port;
            conn_loc_port <= loc_port;
            loc_seq       <= isn;
            loc_ack       <= rx_seq + 1;
            rem_seq       <= rx_seq;
            state         <= send_syn_ack;
          end
        end
        send_syn_ack : begin
          status    <= ST_CONNECTING;
          timer_run <= 1'b1;
          send_req  <= 1'b1;
          hdr_flags <= FLAG_SYN | FLAG_ACK;
          hdr_seq   <= loc_seq;
          hdr_ack   <= loc_ack;
          state     <= syn_ack_sent;
        end
        syn_ack_sent : begin
          if (ack_seen) begin
            loc_seq <= loc_seq + 1;
            rem_seq <= rx_seq;
            state   <= established;
          end
        end

        established : begin
          status    <= ST_CONNECTED;
          timer_run <= 1'b0;    // Lets the timer restart for the close
          if (usr_close) begin
            close_kind <= close_active;
            state      <= send_fin;
          end else if (fin_seen) begin
            close_kind <= close_passive;
            state      <= dcn_send_ack;
          end else if (rst_seen) begin
            close_kind <= close_reset;
            state      <= send_rst;
          end
        end

        ////////////////////
        // Close
        ////////////////////
        send_fin : begin
          status    <= ST_DISCONNECTING;
          timer_run <= 1'b1;
          send_req  <= 1'b1;
          hdr_flags <= FLAG_FIN | FLAG_ACK;
          hdr_seq   <= loc_seq;
          hdr_ack   <= loc_ack;
          state     <= fin_sent;
        end
        fin_sent : begin
          if (conn_ack_seen) fin_acked <= 1'b1;
          // Active side answers the remote FIN once our own FIN is covered
          if (close_kind == close_active && fin_seen && (fin_acked || conn_ack_seen)) begin
            state <= dcn_send_ack;
          end
        end
        dcn_send_ack : begin
          status    <= ST_DISCONNECTING;
          timer_run <= 1'b1;
          send_req  <= 1'b1;
          hdr_flags <= FLAG_ACK;
          hdr_seq   <= loc_seq;
          hdr_ack   <= loc_ack + 1; // Remote FIN takes one number
          state     <= dcn_ack_sent;
        end
        dcn_ack_sent : begin
          // Commit the FIN number only once the ACK is taken
          if (seg_acc && close_kind != close_reset) loc_ack <= loc_ack + 1;
          if (seg_done && close_kind == close_passive) state <= send_fin;
        end
        send_rst : begin
          status    <= ST_DISCONNECTING;
          timer_run <= 1'b1;
          send_req  <= 1'b1;
          hdr_flags <= FLAG_RST | FLAG_ACK;
          hdr_seq   <= loc_seq;
          hdr_ack   <= loc_ack;
          state     <= dcn_ack_sent; // Same wait for the segment to leave
        end
        default : state <= closed;
      endcase
    end
  end

endmodule

// File: source/tcp_rx_classify.sv
`timescale 1ns/1ps

module tcp_rx_classify (
  input  logic                             rx_val,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  rx_dst_port,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  rx_src_port,
  input  logic [tcp_conn_pkg::FLAGS_W-1:0] rx_flags,
  input  logic [tcp_conn_pkg::NUM_W-1:0]   rx_seq,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  conn_loc_port,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  conn_rem_port,
  input  logic [tcp_conn_pkg::NUM_W-1:0]   rem_seq,
  input  logic [tcp_conn_pkg::PORT_W-1:0]  loc_port,
  output logic                             syn_seen,
  output logic                             syn_ack_seen,
  output logic                             ack_seen,
  output logic                             fin_seen,
  output logic                             rst_seen,
  output logic                             conn_ack_seen
);

  import tcp_conn_pkg::*;

  logic loc_hit;  // Addressed to the user's open port
  logic conn_hit; // Belongs to the current connection
  logic has_syn;
  logic has_ack;
  logic has_fin;
  logic has_rst;

  assign loc_hit  = rx_val && (rx_dst_port == loc_port);
  assign conn_hit = rx_val && (rx_src_port == conn_rem_port) && (rx_dst_port == conn_loc_port);

  assign has_syn = |(rx_flags & FLAG_SYN);
  assign has_ack = |(rx_flags & FLAG_ACK);
  assign has_fin = |(rx_flags & FLAG_FIN);
  assign has_rst = |(rx_flags & FLAG_RST);

  ////////////////////
  // Opening events
  ////////////////////
  assign syn_seen     = loc_hit && (rx_flags == FLAG_SYN); // Bare SYN only
  assign syn_ack_seen = loc_hit && has_syn && has_ack;

  ////////////////////
  // Connection events
  ////////////////////
  // Third step of the handshake must carry the next remote number
  assign ack_seen      = conn_hit && has_ack && (rx_seq == rem_seq + 1);
  assign conn_ack_seen = conn_hit && has_ack;
  assign fin_seen      = conn_hit && has_fin;
  assign rst_seen      = conn_hit && has_rst;

endmodule

// File: source/tcp_conn_timer.sv
`timescale 1ns/1ps

module tcp_conn_timer (
  input  logic clk,
  input  logic rst_rec,
  input  logic run,
  output logic timeout
);

  import tcp_conn_pkg::*;

  logic [31:0] cnt;

  always_ff @(posedge clk) begin
    if (rst_rec || !run) begin
      cnt     <= '0;
      timeout <= 1'b0;
    end else if (cnt == CONN_TIMEOUT_TICKS - 1) begin
      cnt     <= '0;   // Restart, another full period before the next pulse
      timeout <= 1'b1;
    end else begin
      cnt     <= cnt + 1;
      timeout <= 1'b0;
    end
  end

endmodule

// File: source/tcp_seq_lfsr.sv
`timescale 1ns/1ps

module tcp_seq_lfsr (
  input  logic                           clk,
  input  logic                           rst_rec,
  output logic [tcp_conn_pkg::NUM_W-1:0] value
);

  import tcp_conn_pkg::*;

  // Galois form, shifts right and folds the feedback taps in when bit 0 drops out
  always_ff @(posedge clk) begin
    if (rst_rec) begin
      value <= LFSR_SEED;
    end else if (value[0]) begin
      value <= (value >> 1) ^ LFSR_POLY;
    end else begin
      value <= value >> 1;
    end
  end

endmodule

// File: source/tcp_conn_pkg.sv
package tcp_conn_pkg;

  localparam int PORT_W   = 16; // TCP port
  localparam int NUM_W    = 32; // Sequence and acknowledge numbers
  localparam int ADDR_W   = 32; // IPv4 address
  localparam int FLAGS_W  = 8;
  localparam int STATUS_W = 3;

  // TCP flag byte, standard bit positions
  localparam logic [FLAGS_W-1:0] FLAG_FIN = 8'h01;
  localparam logic [FLAGS_W-1:0] FLAG_SYN = 8'h02;
  localparam logic [FLAGS_W-1:0] FLAG_RST = 8'h04;
  localparam logic [FLAGS_W-1:0] FLAG_ACK = 8'h10;

  // Connection status seen by the user
  localparam logic [STATUS_W-1:0] ST_CLOSED        = 3'd0;
  localparam logic [STATUS_W-1:0] ST_LISTENING     = 3'd1;
  localparam logic [STATUS_W-1:0] ST_CONNECTING    = 3'd2;
  localparam logic [STATUS_W-1:0] ST_CONNECTED     = 3'd3;
  localparam logic [STATUS_W-1:0] ST_DISCONNECTING = 3'd4;

  localparam logic [15:0] WINDOW_SIZE        = 16'd4000;
  localparam logic [31:0] CONN_TIMEOUT_TICKS = 32'd2000; // Short, keeps simulation fast
  localparam logic [31:0] LFSR_POLY          = 32'hB4BC_D35C;
  localparam logic [31:0] LFSR_SEED          = 32'h1F2E_3D4C;

  ////////////////////
  // FSM states
  ////////////////////
  localparam logic [4:0] closed       = 5'd0;
  localparam logic [4:0] listen       = 5'd1;
  localparam logic [4:0] send_syn     = 5'd2;
  localparam logic [4:0] syn_sent     = 5'd3;
  localparam logic [4:0] send_ack     = 5'd4;
  localparam logic [4:0] ack_sent     = 5'd5;
  localparam logic [4:0] send_syn_ack = 5'd6;
  localparam logic [4:0] syn_ack_sent = 5'd7;
  localparam logic [4:0] established  = 5'd8;
  localparam logic [4:0] send_fin     = 5'd9;
  localparam logic [4:0] fin_sent     = 5'd10;
  localparam logic [4:0] dcn_send_ack = 5'd11;
  localparam logic [4:0] dcn_ack_sent = 5'd12;
  localparam logic [4:0] send_rst     = 5'd13;

  // How the connection is being closed
  localparam logic [1:0] close_none    = 2'd0;
  localparam logic [1:0] close_active  = 2'd1;
  localparam logic [1:0] close_passive = 2'd2;
  localparam logic [1:0] close_reset   = 2'd3;

endpackage
